// ==== mini_mips.f ====
verilog/cpu_types_pkg.sv
verilog/pipe_types_pkg.sv
verilog/fetch_unit.sv
verilog/fetch_queue.sv
verilog/register_file.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/execute_unit.sv
verilog/datapath.sv
test/datapath_checker.sv
test/datapath_tb.sv

// ==== test/datapath_checker.sv ====
/*
  datapath checker
  compares completed data-port stores with the expected pair and watches halt
*/
`default_nettype none

module datapath_checker (
	input  logic                      CLK,
	input  logic                      nRST,
	input  pipe_types_pkg::dmem_req_t dmem_req,
	input  logic                      dhit,
	input  logic                      halt,
	output int                        passed,
	output int                        failed
);
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_types_pkg::*;

	logic  active;
	int    test_idx;
	string test_label;
	word_t exp_addr;
	word_t exp_data;
	int    errors;
	logic  store_seen;
	logic  halt_seen;

	initial begin
		active     = 1'b0;
		passed     = 0;
		failed     = 0;
		errors     = 0;
		store_seen = 1'b0;
		halt_seen  = 1'b0;
	end

	task automatic start_test(input int idx, input string label, input word_t addr,
	                          input word_t data);
		test_idx   = idx;
		test_label = label;
		exp_addr   = addr;
		exp_data   = data;
		errors     = 0;
		store_seen = 1'b0;
		halt_seen  = 1'b0;
		active     = 1'b1;
	endtask

	task automatic end_test(input logic expired);
		logic ok;
		active = 1'b0;
		if (expired) begin
			$display("test %0d: timed out waiting for halt", test_idx);
		end else if (!store_seen) begin
			$display("test %0d: no store to %h was seen before halt", test_idx, exp_addr);
		end
		ok = !expired && store_seen && (errors == 0);
		if (ok) begin
			passed++;
			$display("test %0d (%s): passed", test_idx, test_label);
		end else begin
			failed++;
			$display("test %0d (%s): failed", test_idx, test_label);
		end
	endtask

	task automatic report_counts();
		$display("%0d tests run: %0d passed, %0d failed", passed + failed, passed, failed);
	endtask

	// sampled on the rising edge, memory answers change on the falling one
	always @(posedge CLK) begin
		if (active && nRST) begin
			if (halt === 1'b1) begin
				halt_seen = 1'b1;
			end else if (halt_seen) begin
				$display("FAIL %0t: test %0d halt dropped after being set", $time, test_idx);
				errors++;
			end

			if (dmem_req.wen === 1'b1 && dhit) begin
				if (halt_seen) begin
					$display("FAIL %0t: test %0d store to %h after halt",
					         $time, test_idx, dmem_req.addr);
					errors++;
				end else if (dmem_req.addr == exp_addr) begin
					store_seen = 1'b1;
					if (dmem_req.store !== exp_data) begin
						$display("FAIL %0t: test %0d stored %h at %h, expected %h",
						         $time, test_idx, dmem_req.store, exp_addr, exp_data);
						errors++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/datapath_tb.sv ====
/*
  datapath testbench
  runs a table of small programs against memory models with random hit delays
*/
`default_nettype none

module datapath_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	localparam int    NUM_TESTS  = 6;
	localparam int    PROG_WORDS = 16;
	localparam int    MAX_CYCLES = 2000;
	localparam int    HALT_HOLD  = 20;
	localparam word_t STORE_ADDR = 32'h0000_0080;

	logic      CLK;
	logic      nRST;
	imem_req_t imem_req;
	logic      ihit;
	word_t     imemload;
	dmem_req_t dmem_req;
	logic      dhit;
	word_t     dmemload;
	logic      halt;
	int        passed;
	int        failed;

	integer seed = 32'h7415;

	// word-addressed memory models
	word_t      imem [64];
	word_t      dmem [256];
	logic       ipending;
	word_t      iaddr_q;
	int         iwait;
	logic       dpending;
	word_t      daddr_q;
	int         dwait;
	logic [7:0] didx;

	// program table
	word_t progs     [NUM_TESTS][PROG_WORDS];
	word_t exp_data  [NUM_TESTS];
	string test_name [NUM_TESTS];
	logic  timed_out;

	datapath #(
		.PC_INIT     (32'h0000_0000),
		.QUEUE_DEPTH (4)
	) dut_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.imem_req (imem_req),
		.ihit     (ihit),
		.imemload (imemload),
		.dmem_req (dmem_req),
		.dhit     (dhit),
		.dmemload (dmemload),
		.halt     (halt)
	);

	datapath_checker chk_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.dmem_req (dmem_req),
		.dhit     (dhit),
		.halt     (halt),
		.passed   (passed),
		.failed   (failed)
	);

	always #20 CLK = ~CLK;

	function automatic word_t enc_r(input int rs, input int rt, input int rd,
	                                input int shamt, input funct_t fn);
		return {RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
	endfunction

	function automatic word_t enc_i(input opcode_t op, input int rs, input int rt,
	                                input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	// target is a byte address
	function automatic word_t enc_j(input int target);
		return {J, 26'(target >> 2)};
	endfunction

	// instruction port answers each request after 0 to 3 cycles
	always @(negedge CLK) begin
		if (imem_req.ren === 1'b1) begin
			if (!ipending || imem_req.addr != iaddr_q) begin
				ipending = 1'b1;
				iaddr_q  = imem_req.addr;
				iwait    = $random(seed) & 3;
			end
			if (iwait == 0) begin
				ihit     <= 1'b1;
				imemload <= imem[imem_req.addr[7:2]];
				ipending = 1'b0;
			end else begin
				ihit  <= 1'b0;
				iwait = iwait - 1;
			end
		end else begin
			ihit     <= 1'b0;
			ipending = 1'b0;
		end
	end

	// data port uses the same handshake
	always @(negedge CLK) begin
		if (dmem_req.ren === 1'b1 || dmem_req.wen === 1'b1) begin
			if (!dpending || dmem_req.addr != daddr_q) begin
				dpending = 1'b1;
				daddr_q  = dmem_req.addr;
				dwait    = $random(seed) & 3;
			end
			if (dwait == 0) begin
				didx = dmem_req.addr[9:2];
				dhit <= 1'b1;
				if (dmem_req.wen) begin
					dmem[didx] = dmem_req.store;
				end else begin
					dmemload <= dmem[didx];
				end
				dpending = 1'b0;
			end else begin
				dhit  <= 1'b0;
				dwait = dwait - 1;
			end
		end else begin
			dhit     <= 1'b0;
			dpending = 1'b0;
		end
	end

	task automatic fill_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			for (int k = 0; k < PROG_WORDS; k++) begin
				progs[t][k] = '0;
			end
		end

		// signed SLT gives 1 and 0 so the sum is 0x50 - 3 + 1 - 0
		test_name[0] = "alu arithmetic";
		progs[0][0]  = enc_i(ADDIU, 0, 1, 7);
		progs[0][1]  = enc_i(ADDIU, 0, 2, -3);
		progs[0][2]  = enc_r(1, 2, 3, 0, FN_ADDU);
		progs[0][3]  = enc_r(1, 3, 4, 0, FN_SUBU);
		progs[0][4]  = enc_r(1, 2, 5, 0, FN_AND);
		progs[0][5]  = enc_r(5, 3, 6, 0, FN_OR);
		progs[0][6]  = enc_r(2, 1, 7, 0, FN_SLT);
		progs[0][7]  = enc_r(0, 6, 8, 4, FN_SLL);
		progs[0][8]  = enc_r(1, 2, 10, 0, FN_SLT);
		progs[0][9]  = enc_r(8, 4, 11, 0, FN_SUBU);
		progs[0][10] = enc_r(11, 7, 11, 0, FN_ADDU);
		progs[0][11] = enc_r(11, 10, 11, 0, FN_SUBU);
		progs[0][12] = enc_i(SW, 0, 11, 'h80);
		progs[0][13] = enc_i(HALT, 0, 0, 0);
		exp_data[0]  = 32'h0000_004e;

		// 0x1234abcd - 16 + 0x8000
		test_name[1] = "immediates";
		progs[1][0]  = enc_i(LUI, 0, 1, 'h1234);
		progs[1][1]  = enc_i(ORI, 1, 1, 'habcd);
		progs[1][2]  = enc_i(ADDIU, 0, 2, -16);
		progs[1][3]  = enc_r(1, 2, 3, 0, FN_ADDU);
		progs[1][4]  = enc_i(ORI, 0, 4, 'h8000);
		progs[1][5]  = enc_r(3, 4, 3, 0, FN_ADDU);
		progs[1][6]  = enc_i(SW, 0, 3, 'h80);
		progs[1][7]  = enc_i(HALT, 0, 0, 0);
		exp_data[1]  = 32'h1235_2bbd;

		// two loads of 0xcafe0055 summed plus 0x55
		test_name[2] = "load and store";
		progs[2][0]  = enc_i(ADDIU, 0, 1, 'h55);
		progs[2][1]  = enc_i(LUI, 0, 2, 'hcafe);
		progs[2][2]  = enc_r(2, 1, 2, 0, FN_OR);
		progs[2][3]  = enc_i(SW, 0, 2, 'h40);
		progs[2][4]  = enc_i(LW, 0, 3, 'h40);
		progs[2][5]  = enc_i(ADDIU, 0, 4, 'h20);
		progs[2][6]  = enc_i(LW, 4, 5, 'h20);
		progs[2][7]  = enc_r(3, 5, 6, 0, FN_ADDU);
		progs[2][8]  = enc_r(6, 1, 6, 0, FN_ADDU);
		progs[2][9]  = enc_i(SW, 0, 6, 'h80);
		progs[2][10] = enc_i(HALT, 0, 0, 0);
		exp_data[2]  = 32'h95fc_00ff;

		// squashed words would add 0x100, 0x200, 0x400 or 0x800
		test_name[3] = "branches and jump";
		progs[3][0]  = enc_i(ADDIU, 0, 1, 1);
		progs[3][1]  = enc_i(ADDIU, 0, 2, 1);
		progs[3][2]  = enc_i(BEQ, 1, 2, 2);
		progs[3][3]  = enc_i(ADDIU, 3, 3, 'h100);
		progs[3][4]  = enc_i(ADDIU, 3, 3, 'h200);
		progs[3][5]  = enc_i(ADDIU, 3, 3, 1);
		progs[3][6]  = enc_i(BNE, 1, 2, 1);
		progs[3][7]  = enc_i(ADDIU, 3, 3, 2);
		progs[3][8]  = enc_j(44);
		progs[3][9]  = enc_i(ADDIU, 3, 3, 'h400);
		progs[3][10] = enc_i(ADDIU, 3, 3, 'h800);
		progs[3][11] = enc_i(SW, 0, 3, 'h80);
		progs[3][12] = enc_i(HALT, 0, 0, 0);
		exp_data[3]  = 32'h0000_0003;

		test_name[4] = "r0 and loop";
		progs[4][0]  = enc_i(ADDIU, 0, 0, 'h7f);
		progs[4][1]  = enc_i(ADDIU, 0, 1, 5);
		progs[4][2]  = enc_i(ADDIU, 2, 2, 1);
		progs[4][3]  = enc_i(BNE, 2, 1, -2);
		progs[4][4]  = enc_r(2, 0, 4, 0, FN_ADDU);
		progs[4][5]  = enc_i(SW, 0, 4, 'h80);
		progs[4][6]  = enc_i(HALT, 0, 0, 0);
		exp_data[4]  = 32'h0000_0005;

		// stores after HALT must never reach the port
		test_name[5] = "halt";
		progs[5][0]  = enc_i(ADDIU, 0, 1, 'h2a);
		progs[5][1]  = enc_i(SW, 0, 1, 'h80);
		progs[5][2]  = enc_i(HALT, 0, 0, 0);
		progs[5][3]  = enc_i(SW, 0, 1, 'h84);
		progs[5][4]  = enc_i(ADDIU, 1, 1, 1);
		progs[5][5]  = enc_i(SW, 0, 1, 'h80);
		exp_data[5]  = 32'h0000_002a;
	endtask

	task automatic load_program(input int t);
		for (int i = 0; i < 64; i++) begin
			imem[i] = (i < PROG_WORDS) ? progs[t][i] : '0;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = 32'hd00d_0000 | (i * 4);
		end
	endtask

	task automatic wait_for_halt(output logic expired);
		int n;
		n = 0;
		while (halt !== 1'b1 && n < MAX_CYCLES) begin
			@(negedge CLK);
			n++;
		end
		expired = (halt !== 1'b1);
	endtask

	initial begin
		CLK      = 1'b0;
		nRST     = 1'b0;
		ihit     = 1'b0;
		dhit     = 1'b0;
		imemload = '0;
		dmemload = '0;
		ipending = 1'b0;
		dpending = 1'b0;
		iwait    = 0;
		dwait    = 0;
		fill_table();

		for (int t = 0; t < NUM_TESTS; t++) begin
			@(negedge CLK);
			load_program(t);
			nRST = 1'b0;
			repeat (4) @(negedge CLK);
			nRST = 1'b1;
			chk_i.start_test(t, test_name[t], STORE_ADDR, exp_data[t]);
			wait_for_halt(timed_out);
			// halt must hold while the checker keeps watching
			if (!timed_out) begin
				repeat (HALT_HOLD) @(negedge CLK);
			end
			chk_i.end_test(timed_out);
		end

		chk_i.report_counts();
		if (failed == 0 && passed == NUM_TESTS) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
/*
  ALU
  32-bit add, sub, logic ops, signed compare, shift and upper-immediate
*/
`default_nettype none

module alu (
	input  cpu_types_pkg::word_t  a,
	input  cpu_types_pkg::word_t  b,
	input  cpu_types_pkg::aluop_t op,
	output cpu_types_pkg::word_t  result,
	output logic                  zero
);
	import cpu_types_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			// shift amount arrives on a
			ALU_SLL: result = b << a[4:0];
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
/*
  control unit
  decodes an instruction word into the control bundle
*/
`default_nettype none

module control_unit (
	input  cpu_types_pkg::word_t   instr,
	output pipe_types_pkg::ctrl_t  ctrl
);
	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	r_t r_fmt;

	assign r_fmt = r_t'(instr);

	always_comb begin
		// defaults give a no-op
		ctrl           = '0;
		ctrl.alu_op    = ALU_ADD;
		ctrl.alu_src   = SRC_REG;
		ctrl.branch    = BR_NONE;

		case (r_fmt.opcode)
			RTYPE: begin
				ctrl.reg_dst   = 1'b1;
				ctrl.reg_write = 1'b1;
				case (r_fmt.funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_SLL: begin
						ctrl.alu_op  = ALU_SLL;
						ctrl.alu_src = SRC_SHAMT;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			ADDIU: begin
				ctrl.alu_src   = SRC_SEXT;
				ctrl.reg_write = 1'b1;
			end
			ORI: begin
				ctrl.alu_op    = ALU_OR;
				ctrl.alu_src   = SRC_ZEXT;
				ctrl.reg_write = 1'b1;
			end
			LUI: begin
				ctrl.alu_op    = ALU_LUI;
				ctrl.alu_src   = SRC_ZEXT;
				ctrl.reg_write = 1'b1;
			end
			LW: begin
				ctrl.alu_src   = SRC_SEXT;
				ctrl.reg_write = 1'b1;
				ctrl.load      = 1'b1;
			end
			SW: begin
				ctrl.alu_src = SRC_SEXT;
				ctrl.store   = 1'b1;
			end
			// compare by subtraction, ALU zero flag decides
			BEQ: begin
				ctrl.alu_op = ALU_SUB;
				ctrl.branch = BR_EQ;
			end
			BNE: begin
				ctrl.alu_op = ALU_SUB;
				ctrl.branch = BR_NE;
			end
			J:       ctrl.jump = 1'b1;
			HALT:    ctrl.halt = 1'b1;
			default: ctrl.reg_write = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_types_pkg.sv ====
/*
  cpu types
  instruction formats, opcode and funct encodings, ALU operations
*/
`default_nettype none

package cpu_types_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regbits_t;

	// primary opcodes
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		ORI   = 6'h0d,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// r-type function field
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SUB = 4'h1,
		ALU_AND = 4'h2,
		ALU_OR  = 4'h3,
		ALU_SLT = 4'h4,
		ALU_SLL = 4'h5,
		ALU_LUI = 4'h6
	} aluop_t;

	typedef struct packed {
		opcode_t     opcode;
		regbits_t    rs;
		regbits_t    rt;
		regbits_t    rd;
		logic [4:0]  shamt;
		funct_t      funct;
	} r_t;

	typedef struct packed {
		opcode_t     opcode;
		regbits_t    rs;
		regbits_t    rt;
		logic [15:0] imm;
	} i_t;

	typedef struct packed {
		opcode_t     opcode;
		logic [25:0] addr;
	} j_t;

endpackage

`default_nettype wire

// ==== verilog/datapath.sv ====
/*
  datapath top
  fetch unit feeding a fetch queue that feeds the execute unit
*/
`default_nettype none

module datapath #(
	parameter cpu_types_pkg::word_t PC_INIT = '0,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                      CLK,
	input  logic                      nRST,
	output pipe_types_pkg::imem_req_t imem_req,
	input  logic                      ihit,
	input  cpu_types_pkg::word_t      imemload,
	output pipe_types_pkg::dmem_req_t dmem_req,
	input  logic                      dhit,
	input  cpu_types_pkg::word_t      dmemload,
	output logic                      halt
);
	import pipe_types_pkg::*;

	logic       push;
	logic       pop;
	logic       full;
	logic       empty;
	fetch_pkt_t push_pkt;
	fetch_pkt_t head_pkt;
	redirect_t  redirect;

	fetch_unit #(
		.PC_INIT (PC_INIT)
	) fetch_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.full     (full),
		.ihit     (ihit),
		.halt     (halt),
		.redirect (redirect),
		.imemload (imemload),
		.imem_req (imem_req),
		.push     (push),
		.push_pkt (push_pkt)
	);

	fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) queue_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.push     (push),
		.push_pkt (push_pkt),
		.pop      (pop),
		.redirect (redirect),
		.full     (full),
		.empty    (empty),
		.head_pkt (head_pkt)
	);

	execute_unit exec_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.empty    (empty),
		.head_pkt (head_pkt),
		.dhit     (dhit),
		.dmemload (dmemload),
		.pop      (pop),
		.redirect (redirect),
		.dmem_req (dmem_req),
		.halt     (halt)
	);

endmodule

`default_nettype wire

// ==== verilog/execute_unit.sv ====
/*
  execute unit
  takes one instruction at a time from the queue and runs it to completion:
  decode, register read, ALU, data access, writeback, redirect and halt
*/
`default_nettype none

module execute_unit (
	input  logic                       CLK,
	input  logic                       nRST,
	input  logic                       empty,
	input  pipe_types_pkg::fetch_pkt_t head_pkt,
	input  logic                       dhit,
	input  cpu_types_pkg::word_t       dmemload,
	output logic                       pop,
	output pipe_types_pkg::redirect_t  redirect,
	output pipe_types_pkg::dmem_req_t  dmem_req,
	output logic                       halt
);
	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		MEM,
		HALTED
	} state_t;

	state_t     state;
	state_t     next_state;
	fetch_pkt_t ir;
	ctrl_t      ctrl;
	r_t         r_fmt;
	i_t         i_fmt;
	j_t         j_fmt;
	word_t      rdat1;
	word_t      rdat2;
	word_t      sext_imm;
	word_t      zext_imm;
	word_t      alu_a;
	word_t      alu_b;
	word_t      alu_out;
	logic       alu_zero;
	regbits_t   wsel;
	word_t      wdat;
	logic       wen;
	logic       active;
	logic       mem_op;
	logic       done;
	logic       taken;
	word_t      branch_target;
	word_t      jump_target;

	assign r_fmt = r_t'(ir.instr);
	assign i_fmt = i_t'(ir.instr);
	assign j_fmt = j_t'(ir.instr);

	control_unit ctrl_i (
		.instr (ir.instr),
		.ctrl  (ctrl)
	);

	register_file rf_i (
		.CLK   (CLK),
		.nRST  (nRST),
		.rsel1 (r_fmt.rs),
		.rsel2 (r_fmt.rt),
		.wsel  (wsel),
		.wen   (wen),
		.wdat  (wdat),
		.rdat1 (rdat1),
		.rdat2 (rdat2)
	);

	assign sext_imm = {{16{i_fmt.imm[15]}}, i_fmt.imm};
	assign zext_imm = {16'h0000, i_fmt.imm};

	// shifts take the amount on a and the value on b
	assign alu_a = (ctrl.alu_src == SRC_SHAMT) ? {27'b0, r_fmt.shamt} : rdat1;

	always_comb begin
		case (ctrl.alu_src)
			SRC_SEXT: alu_b = sext_imm;
			SRC_ZEXT: alu_b = zext_imm;
			default:  alu_b = rdat2;
		endcase
	end

	alu alu_i (
		.a      (alu_a),
		.b      (alu_b),
		.op     (ctrl.alu_op),
		.result (alu_out),
		.zero   (alu_zero)
	);

	assign active = (state == EXEC) || (state == MEM);
	assign mem_op = ctrl.load || ctrl.store;
	// loads and stores finish on dhit, everything else in EXEC
	assign done   = active && (!mem_op || dhit);

	assign wsel = ctrl.reg_dst ? r_fmt.rd : r_fmt.rt;
	assign wdat = ctrl.load ? dmemload : alu_out;
	assign wen  = done && ctrl.reg_write;

	assign dmem_req.ren   = active && ctrl.load;
	assign dmem_req.wen   = active && ctrl.store;
	assign dmem_req.addr  = alu_out;
	assign dmem_req.store = rdat2;

	assign taken = ((ctrl.branch == BR_EQ) && alu_zero) ||
	               ((ctrl.branch == BR_NE) && !alu_zero);

	assign branch_target = ir.npc + {sext_imm[29:0], 2'b00};
	assign jump_target   = {ir.npc[31:28], j_fmt.addr, 2'b00};

	assign redirect.valid  = (state == EXEC) && (taken || ctrl.jump);
	assign redirect.target = ctrl.jump ? jump_target : branch_target;

	assign pop  = (state == IDLE) && !empty;
	assign halt = (state == HALTED);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (!empty) begin
					next_state = EXEC;
				end
			end
			EXEC: begin
				if (ctrl.halt) begin
					next_state = HALTED;
				end else if (mem_op && !dhit) begin
					next_state = MEM;
				end else begin
					next_state = IDLE;
				end
			end
			MEM: begin
				if (dhit) begin
					next_state = IDLE;
				end
			end
			default: next_state = HALTED;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// instruction register
	always_ff @(posedge CLK) begin
		if (pop) begin
			ir <= head_pkt;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fetch_queue.sv ====
/*
  fetch queue
  circular buffer of fetched instructions, emptied on a redirect
*/
`default_nettype none

module fetch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                       CLK,
	input  logic                       nRST,
	input  logic                       push,
	input  pipe_types_pkg::fetch_pkt_t push_pkt,
	input  logic                       pop,
	input  pipe_types_pkg::redirect_t  redirect,
	output logic                       full,
	output logic                       empty,
	output pipe_types_pkg::fetch_pkt_t head_pkt
);
	import pipe_types_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(QUEUE_DEPTH);

	fetch_pkt_t entries [QUEUE_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;

	// anything pushed alongside a redirect belongs to the old path
	assign do_push = push && !redirect.valid;

	assign full     = (count == FULL_COUNT);
	assign empty    = (count == '0);
	assign head_pkt = entries[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push) begin
			entries[wr_ptr] <= push_pkt;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (redirect.valid) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
/*
  fetch unit
  runs the PC ahead of execute and pushes fetched words into the queue
*/
`default_nettype none

module fetch_unit #(
	parameter cpu_types_pkg::word_t PC_INIT = '0
) (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic                     full,
	input  logic                     ihit,
	input  logic                     halt,
	input  pipe_types_pkg::redirect_t redirect,
	input  cpu_types_pkg::word_t     imemload,
	output pipe_types_pkg::imem_req_t imem_req,
	output logic                     push,
	output pipe_types_pkg::fetch_pkt_t push_pkt
);
	import cpu_types_pkg::*;

	word_t pc;
	word_t pc_plus4;

	assign pc_plus4 = pc + 32'd4;

	// back-pressure holds the read enable low instead of dropping words
	// a redirect abandons the request, so a hit in that cycle is ignored
	assign imem_req.ren  = !full && !halt && !redirect.valid;
	assign imem_req.addr = pc;

	assign push           = imem_req.ren && ihit;
	assign push_pkt.instr = imemload;
	assign push_pkt.npc   = pc_plus4;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= PC_INIT;
		end else if (redirect.valid) begin
			pc <= redirect.target;
		end else if (push) begin
			pc <= pc_plus4;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pipe_types_pkg.sv ====
/*
  pipeline types
  bundles passed between fetch, queue and execute, and to the memory ports
*/
`default_nettype none

package pipe_types_pkg;

	// second ALU operand source
	typedef enum logic [1:0] {
		SRC_REG,
		SRC_SEXT,
		SRC_ZEXT,
		SRC_SHAMT
	} alusrc_t;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE
	} branch_t;

	typedef struct packed {
		cpu_types_pkg::word_t instr;
		cpu_types_pkg::word_t npc;
	} fetch_pkt_t;

	typedef struct packed {
		logic                 valid;
		cpu_types_pkg::word_t target;
	} redirect_t;

	typedef struct packed {
		logic                 ren;
		cpu_types_pkg::word_t addr;
	} imem_req_t;

	typedef struct packed {
		logic                 ren;
		logic                 wen;
		cpu_types_pkg::word_t addr;
		cpu_types_pkg::word_t store;
	} dmem_req_t;

	typedef struct packed {
		cpu_types_pkg::aluop_t alu_op;
		alusrc_t               alu_src;
		logic                  reg_dst;
		logic                  reg_write;
		logic                  load;
		logic                  store;
		branch_t               branch;
		logic                  jump;
		logic                  halt;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/register_file.sv ====
/*
  register file
  32 x 32 bits, two combinational reads, one write, r0 reads as zero
*/
`default_nettype none

module register_file (
	input  logic                    CLK,
	input  logic                    nRST,
	input  cpu_types_pkg::regbits_t rsel1,
	input  cpu_types_pkg::regbits_t rsel2,
	input  cpu_types_pkg::regbits_t wsel,
	input  logic                    wen,
	input  cpu_types_pkg::word_t    wdat,
	output cpu_types_pkg::word_t    rdat1,
	output cpu_types_pkg::word_t    rdat2
);
	import cpu_types_pkg::*;

	word_t regs [32];

	// no write bypass, execute never reads and writes in one cycle
	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (wsel != '0)) begin
			regs[wsel] <= wdat;
		end
	end

endmodule

`default_nettype wire
